/* src/at_format_pkg.sv */
// record layout is fixed little endian, reserved command bits are ignored by the decoder
package at_format_pkg;

  // one byte of either stream
  typedef logic [7:0] byte_t;

  // one UUT operand
  typedef logic [31:0] operand_t;

  // UUT output, one bit wider than the operands to hold a carry
  typedef logic [32:0] uut_result_t;

  // UUT rate selection, period is 2**sel system clocks
  typedef logic [1:0] clk_sel_t;

  // bytes per operand in a test record
  localparam int OPERAND_BYTES = $bits(operand_t) / 8;

  // command byte plus two operands
  localparam int REC_IN_BYTES = 1 + 2 * OPERAND_BYTES;

  // status byte plus five result bytes, unused upper result bits are zero
  localparam int REC_OUT_BYTES = 6;

  // clk_sel sits in the low bits of the command byte
  localparam int CMD_SEL_LSB = 0;

endpackage

/* src/at_ctrl_pkg.sv */
// status codes are one byte; only OK and TIMEOUT are ever produced
package at_ctrl_pkg;

  // first byte of every result record
  typedef logic [7:0] at_status_t;

  localparam at_status_t STATUS_OK = 8'h00;
  localparam at_status_t STATUS_TIMEOUT = 8'h01;

  // sequencer phases for one record
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RESET,
    SEQ_RUN,
    SEQ_DONE
  } seq_state_t;

  // decoder field being collected
  typedef enum logic [1:0] {
    DEC_CMD,
    DEC_OPA,
    DEC_OPB
  } dec_state_t;

endpackage

/* src/vector_decoder.sv */
// source must hold IN_CREDITS credits at reset and never send without one
`timescale 1ns/1ps

module vector_decoder import at_format_pkg::*, at_ctrl_pkg::*; #(
  parameter int IN_CREDITS = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  byte_t    in_byte,
  output logic     in_credit,
  output logic     rec_valid,
  input  logic     rec_ready,
  output clk_sel_t rec_sel,
  output operand_t rec_a,
  output operand_t rec_b
);

  localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
  localparam int FILL_W = $clog2(IN_CREDITS + 1);

  byte_t             buf_mem [IN_CREDITS];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FILL_W-1:0] fill;
  logic              pop;
  byte_t             pop_byte;

  dec_state_t        state;
  logic [3:0]        byte_cnt;

  // holding register frees up on the same cycle the sequencer takes it
  assign pop = (fill != '0) && (!rec_valid || rec_ready);
  assign pop_byte = buf_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (in_valid) begin
      buf_mem[wr_ptr] <= in_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill <= fill + FILL_W'(in_valid) - FILL_W'(pop);
      // every popped byte hands one credit back to the source
      in_credit <= pop;
    end
  end

  // record parser
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DEC_CMD;
      byte_cnt <= '0;
      rec_valid <= 1'b0;
    end else begin
      if (rec_valid && rec_ready) begin
        rec_valid <= 1'b0;
      end
      if (pop) begin
        case (state)
          DEC_CMD: begin
            state <= DEC_OPA;
            byte_cnt <= 4'd1;
          end
          DEC_OPA: begin
            if (byte_cnt == 4'(OPERAND_BYTES)) begin
              state <= DEC_OPB;
            end
            byte_cnt <= byte_cnt + 1'b1;
          end
          default: begin
            if (byte_cnt == 4'(REC_IN_BYTES - 1)) begin
              state <= DEC_CMD;
              byte_cnt <= '0;
              rec_valid <= 1'b1;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        endcase
      end
    end
  end

  // operands arrive LSB first, so shift in from the top
  always_ff @(posedge clk) begin
    if (pop) begin
      case (state)
        DEC_CMD: rec_sel <= pop_byte[CMD_SEL_LSB +: $bits(clk_sel_t)];
        DEC_OPA: rec_a <= {pop_byte, rec_a[$bits(operand_t)-1:8]};
        default: rec_b <= {pop_byte, rec_b[$bits(operand_t)-1:8]};
      endcase
    end
  end

  // the source must respect the returned credits
  assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (fill < FILL_W'(IN_CREDITS)))
    else $error("byte pushed into a full input buffer");

endmodule

/* src/uut_clock_gen.sv */
// produces an enable, not a clock; the UUT must be clocked by clk and qualified by uut_clk_en
`timescale 1ns/1ps

module uut_clock_gen import at_format_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  clk_sel_t clk_sel,
  output logic     uut_clk_en
);

  localparam int DIV_W = 3;

  logic [DIV_W-1:0] div_cnt;
  logic [DIV_W-1:0] sel_mask;
  logic             tick;

  // low clk_sel bits of the counter take part in the compare
  assign sel_mask = (DIV_W'(1) << clk_sel) - DIV_W'(1);
  assign tick = &(div_cnt | ~sel_mask);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      uut_clk_en <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      // one pulse per 2**clk_sel cycles
      uut_clk_en <= tick;
    end
  end

endmodule

/* src/uut_sequencer.sv */
// RST_CYCLES must be at least 2; UUT result is only sampled on the first end_uut cycle
`timescale 1ns/1ps

module uut_sequencer import at_format_pkg::*, at_ctrl_pkg::*; #(
  parameter int RST_CYCLES = 4,
  parameter int TIMEOUT_CYCLES = 200
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rec_valid,
  output logic        rec_ready,
  input  clk_sel_t    rec_sel,
  input  operand_t    rec_a,
  input  operand_t    rec_b,
  output clk_sel_t    clk_sel,
  output logic        rst_uut,
  output operand_t    operand_a,
  output operand_t    operand_b,
  input  logic        end_uut,
  input  uut_result_t uut_result,
  output logic        res_valid,
  input  logic        res_ready,
  output at_status_t  res_status,
  output uut_result_t res_data
);

  localparam int MAX_CNT = (TIMEOUT_CYCLES > RST_CYCLES) ? TIMEOUT_CYCLES : RST_CYCLES;
  localparam int CNT_W = $clog2(MAX_CNT + 1);

  seq_state_t       state;
  logic [CNT_W-1:0] cnt;

  assign rec_ready = (state == SEQ_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
      cnt <= '0;
      rst_uut <= 1'b1;
      clk_sel <= '0;
      operand_a <= '0;
      operand_b <= '0;
      res_valid <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (rec_valid) begin
            clk_sel <= rec_sel;
            operand_a <= rec_a;
            operand_b <= rec_b;
            cnt <= '0;
            state <= SEQ_RESET;
          end
        end
        SEQ_RESET: begin
          // release lands RST_CYCLES after the handshake
          if (cnt == CNT_W'(RST_CYCLES - 2)) begin
            rst_uut <= 1'b0;
            cnt <= '0;
            state <= SEQ_RUN;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        SEQ_RUN: begin
          if (end_uut || cnt == CNT_W'(TIMEOUT_CYCLES - 1)) begin
            res_valid <= 1'b1;
            state <= SEQ_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (res_ready) begin
            res_valid <= 1'b0;
            rst_uut <= 1'b1;
            state <= SEQ_IDLE;
          end
        end
      endcase
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (state == SEQ_RUN) begin
      if (end_uut) begin
        res_status <= STATUS_OK;
        res_data <= uut_result;
      end else begin
        res_status <= STATUS_TIMEOUT;
        res_data <= '0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (state == SEQ_RESET) |-> rst_uut)
    else $error("UUT out of reset during reset phase");

  // reset pulse length as seen by the UUT
  assert property (@(posedge clk) disable iff (!rst_n)
    (rec_valid && rec_ready) |-> rst_uut [*RST_CYCLES] ##1 !rst_uut)
    else $error("UUT reset length differs from RST_CYCLES");

endmodule

/* src/result_packer.sv */
// sink must return exactly one out_credit per byte received, starting from OUT_CREDITS
`timescale 1ns/1ps

module result_packer import at_format_pkg::*, at_ctrl_pkg::*; #(
  parameter int OUT_CREDITS = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        res_valid,
  output logic        res_ready,
  input  at_status_t  res_status,
  input  uut_result_t res_data,
  output logic        out_valid,
  output byte_t       out_byte,
  input  logic        out_credit
);

  localparam int CRED_W = $clog2(OUT_CREDITS + 1);
  localparam int SHIFT_W = REC_OUT_BYTES * 8;
  localparam int PAD_W = SHIFT_W - $bits(at_status_t) - $bits(uut_result_t);

  logic [CRED_W-1:0]  credits;
  logic [SHIFT_W-1:0] shift_q;
  logic [2:0]         byte_cnt;
  logic               busy;
  logic               send;

  assign res_ready = !busy;
  assign send = busy && (credits != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CRED_W'(OUT_CREDITS);
      byte_cnt <= '0;
      busy <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      credits <= credits - CRED_W'(send) + CRED_W'(out_credit);
      out_valid <= send;
      if (res_valid && !busy) begin
        busy <= 1'b1;
        byte_cnt <= '0;
      end else if (send) begin
        byte_cnt <= byte_cnt + 1'b1;
        // last byte frees the packer for the next result
        if (byte_cnt == 3'(REC_OUT_BYTES - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // status first, then result bytes LSB first
  always_ff @(posedge clk) begin
    if (res_valid && !busy) begin
      shift_q <= {{PAD_W{1'b0}}, res_data, res_status};
    end else if (send) begin
      shift_q <= shift_q >> 8;
    end
    if (send) begin
      out_byte <= shift_q[7:0];
    end
  end

  // a sink returning more credits than it was given breaks the flow control
  assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CRED_W'(OUT_CREDITS))
    else $error("output credit counter above OUT_CREDITS");

endmodule

/* src/autotest_top.sv */
// UUT runs on clk qualified by uut_clk_en; storage host is outside, reached through the byte streams
`timescale 1ns/1ps

module autotest_top import at_format_pkg::*, at_ctrl_pkg::*; #(
  parameter int IN_CREDITS = 4,
  parameter int OUT_CREDITS = 2,
  parameter int RST_CYCLES = 4,
  parameter int TIMEOUT_CYCLES = 200
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  byte_t       in_byte,
  output logic        in_credit,
  output logic        out_valid,
  output byte_t       out_byte,
  input  logic        out_credit,
  output logic        rst_uut,
  output logic        uut_clk_en,
  output operand_t    operand_a,
  output operand_t    operand_b,
  input  logic        end_uut,
  input  uut_result_t uut_result
);

  // decoder to sequencer
  logic        rec_valid;
  logic        rec_ready;
  clk_sel_t    rec_sel;
  operand_t    rec_a;
  operand_t    rec_b;

  // sequencer to packer
  logic        res_valid;
  logic        res_ready;
  at_status_t  res_status;
  uut_result_t res_data;

  clk_sel_t    clk_sel;

  vector_decoder #(
    .IN_CREDITS(IN_CREDITS)
  ) decoder_i (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_byte(in_byte),
    .in_credit(in_credit),
    .rec_valid(rec_valid),
    .rec_ready(rec_ready),
    .rec_sel(rec_sel),
    .rec_a(rec_a),
    .rec_b(rec_b)
  );

  uut_clock_gen clock_gen_i (
    .clk(clk),
    .rst_n(rst_n),
    .clk_sel(clk_sel),
    .uut_clk_en(uut_clk_en)
  );

  uut_sequencer #(
    .RST_CYCLES(RST_CYCLES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) sequencer_i (
    .clk(clk),
    .rst_n(rst_n),
    .rec_valid(rec_valid),
    .rec_ready(rec_ready),
    .rec_sel(rec_sel),
    .rec_a(rec_a),
    .rec_b(rec_b),
    .clk_sel(clk_sel),
    .rst_uut(rst_uut),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .end_uut(end_uut),
    .uut_result(uut_result),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res_status(res_status),
    .res_data(res_data)
  );

  result_packer #(
    .OUT_CREDITS(OUT_CREDITS)
  ) packer_i (
    .clk(clk),
    .rst_n(rst_n),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res_status(res_status),
    .res_data(res_data),
    .out_valid(out_valid),
    .out_byte(out_byte),
    .out_credit(out_credit)
  );

endmodule

/* testbench/autotest_tb.sv */
// run from the project root so the vector file resolves; the UUT model is a 33-bit adder
`timescale 1ns/1ps

module autotest_tb import at_format_pkg::*, at_ctrl_pkg::*; ();

  localparam int IN_CREDITS = 4;
  localparam int OUT_CREDITS = 2;
  localparam int RST_CYCLES = 4;
  localparam int TIMEOUT_CYCLES = 200;
  // enable pulses the UUT model needs before it ends
  localparam int UUT_PULSES = 3;
  localparam int OUT_BITS = 8 * REC_OUT_BYTES;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  byte_t       in_byte;
  logic        in_credit;
  logic        out_valid;
  byte_t       out_byte;
  logic        out_credit;
  logic        rst_uut;
  logic        uut_clk_en;
  operand_t    operand_a;
  operand_t    operand_b;
  logic        end_uut;
  uut_result_t uut_result;

  // one entry per test, in file order
  clk_sel_t    sel_q[$];
  operand_t    a_q[$];
  operand_t    b_q[$];
  logic        hang_q[$];
  at_status_t  status_q[$];
  uut_result_t result_q[$];
  byte_t       stream_q[$];

  int   n_tests;
  logic loaded;
  int   rec_done;
  int   bytes_sent;
  int   credits_back;
  int   seed;

  autotest_top #(
    .IN_CREDITS(IN_CREDITS),
    .OUT_CREDITS(OUT_CREDITS),
    .RST_CYCLES(RST_CYCLES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_byte(in_byte),
    .in_credit(in_credit),
    .out_valid(out_valid),
    .out_byte(out_byte),
    .out_credit(out_credit),
    .rst_uut(rst_uut),
    .uut_clk_en(uut_clk_en),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .end_uut(end_uut),
    .uut_result(uut_result)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_operand(input string name, input operand_t got, input operand_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input at_status_t got,
                              input at_status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_result(input string name, input uut_result_t got,
                              input uut_result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    clk_sel_t    sel;
    operand_t    a;
    operand_t    b;
    logic        hang;
    at_status_t  st;
    uut_result_t res;
    fd = $fopen("testbench/autotest_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/autotest_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // comment and blank lines do not scan as six fields
      n = $sscanf(line, "%h %h %h %h %h %h", sel, a, b, hang, st, res);
      if (n == 6) begin
        sel_q.push_back(sel);
        a_q.push_back(a);
        b_q.push_back(b);
        hang_q.push_back(hang);
        status_q.push_back(st);
        result_q.push_back(res);
      end
    end
    $fclose(fd);
    n_tests = sel_q.size();
    if (n_tests == 0) begin
      abort_run("vector file holds no tests");
    end
  endtask

  // command byte carries junk in the reserved bits on purpose
  function automatic void build_stream();
    for (int t = 0; t < n_tests; t++) begin
      stream_q.push_back(byte_t'((t << 2) | sel_q[t]));
      for (int k = 0; k < OPERAND_BYTES; k++) begin
        stream_q.push_back(a_q[t][8*k +: 8]);
      end
      for (int k = 0; k < OPERAND_BYTES; k++) begin
        stream_q.push_back(b_q[t][8*k +: 8]);
      end
    end
  endfunction

  // mostly short gaps, one in four a long stall
  function automatic int next_hold();
    int r;
    r = $unsigned($random(seed)) % 64;
    if (r < 16) begin
      return 16 + 2 * r;
    end
    return r % 3;
  endfunction

  task automatic check_record(input logic [OUT_BITS-1:0] bits);
    at_status_t  st;
    uut_result_t res;
    st = bits[7:0];
    res = bits[8 +: $bits(uut_result_t)];
    if (rec_done >= n_tests) begin
      abort_run("more result records arrived than there are tests");
    end
    check_status("res_status", st, status_q[rec_done]);
    check_result("res_data", res, result_q[rec_done]);
    check_count("result padding", int'(bits >> (8 + $bits(uut_result_t))), 0);
    rec_done++;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_byte = '0;
    out_credit = 1'b0;
    end_uut = 1'b0;
    uut_result = '0;
    loaded = 1'b0;
    rec_done = 0;
    bytes_sent = 0;
    credits_back = 0;
    seed = 33269;
    load_vectors();
    build_stream();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait (rec_done == n_tests);
    // let the last credits settle
    repeat (20) @(posedge clk);
    #1;
    check_count("in_credit pulses", credits_back, bytes_sent);
    $display("Simulation PASSED");
    $finish;
  end

  // storage source, sends back to back as far as credits allow
  initial begin : storage_source
    int credits;
    int idx;
    credits = IN_CREDITS;
    idx = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      if (in_credit) begin
        credits++;
        credits_back++;
      end
      if (credits > IN_CREDITS) begin
        abort_run("decoder returned more input credits than bytes sent");
      end
      if (credits > 0 && idx < stream_q.size()) begin
        in_valid = 1'b1;
        in_byte = stream_q[idx];
        idx++;
        credits--;
        bytes_sent++;
      end else begin
        in_valid = 1'b0;
      end
    end
  end

  // storage sink, returns credits after random holds
  initial begin : storage_sink
    int                  owed;
    int                  hold;
    int                  nbytes;
    logic [OUT_BITS-1:0] rec_bits;
    owed = 0;
    hold = 0;
    nbytes = 0;
    rec_bits = '0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      if (out_valid) begin
        owed++;
        if (owed > OUT_CREDITS) begin
          abort_run("packer sent more bytes than the sink had credits for");
        end
        // bytes arrive LSB first
        rec_bits = {out_byte, rec_bits[OUT_BITS-1:8]};
        nbytes++;
        if (nbytes == REC_OUT_BYTES) begin
          check_record(rec_bits);
          nbytes = 0;
        end
      end
      if (hold > 0) begin
        hold--;
        out_credit = 1'b0;
      end else if (owed > 0) begin
        out_credit = 1'b1;
        owed--;
        hold = next_hold();
      end else begin
        out_credit = 1'b0;
      end
    end
  end

  // UUT model, also checks reset length, operands and enable spacing
  initial begin : uut_model
    int   cur;
    int   pulses;
    int   cyc;
    int   last_pulse;
    int   rst_len;
    logic in_run;
    cur = -1;
    pulses = 0;
    cyc = 0;
    last_pulse = -1;
    rst_len = 0;
    in_run = 1'b0;
    wait (loaded === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      cyc++;
      if (rst_uut !== 1'b0) begin
        in_run = 1'b0;
        pulses = 0;
        rst_len++;
        end_uut = 1'b0;
        uut_result = '0;
      end else begin
        if (!in_run) begin
          // first cycle after reset release
          in_run = 1'b1;
          cur++;
          last_pulse = -1;
          if (cur >= n_tests) begin
            abort_run("UUT released more often than there are tests");
          end
          if (rst_len < RST_CYCLES) begin
            abort_run($sformatf("Fail rst_uut: high for 0x%h cycles, expected at least 0x%h",
                                rst_len, RST_CYCLES));
          end
          rst_len = 0;
          check_operand("operand_a", operand_a, a_q[cur]);
          check_operand("operand_b", operand_b, b_q[cur]);
        end
        if (uut_clk_en) begin
          if (last_pulse >= 0) begin
            check_count("uut_clk_en spacing", cyc - last_pulse, 1 << sel_q[cur]);
          end
          last_pulse = cyc;
          if (!hang_q[cur] && pulses < UUT_PULSES) begin
            pulses++;
            if (pulses == UUT_PULSES) begin
              end_uut = 1'b1;
              uut_result = {1'b0, operand_a} + {1'b0, operand_b};
            end
          end
        end
      end
    end
  end

  // watchdog scaled by the number of tests
  initial begin : watchdog
    wait (loaded === 1'b1);
    #((n_tests * (TIMEOUT_CYCLES + 100) + 20) * 10);
    abort_run("watchdog expired before all result records arrived");
  end

endmodule

/* testbench/autotest_vectors.txt */
# columns: clk_sel operand_a operand_b hang status result, all hex
# hang 1 keeps end_uut low, so the record must time out with a zero result
0 00000001 00000002 0 00 000000003
1 12345678 87654321 0 00 099999999
2 ffffffff 00000001 0 00 100000000
3 deadbeef 01010101 0 00 0dfaebff0
1 aaaaaaaa 55555555 1 01 000000000
0 80000000 80000000 0 00 100000000
2 00000000 00000000 0 00 000000000
3 00000001 00000002 1 01 000000000
0 7fffffff 7fffffff 0 00 0fffffffe
1 ffffffff ffffffff 0 00 1fffffffe
2 0badf00d 10203040 0 00 01bce204d
3 13579bdf 02468ace 0 00 0159e26ad

/* autotest.f */
src/at_format_pkg.sv
src/at_ctrl_pkg.sv
src/vector_decoder.sv
src/uut_clock_gen.sv
src/uut_sequencer.sv
src/result_packer.sv
src/autotest_top.sv
testbench/autotest_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = autotest_tb
FILELIST  = autotest.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation FAILED
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "failure reported, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
